// ==== rv_core.f ====
+incdir+test
rtl/rv_pkg.sv
rtl/rv_hazard_if.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_hazard.sv
rtl/rv_core.sv
test/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f rv_core.f \
  --top-module tb_rv_core -Mdir "$OBJ" -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$OBJ/sim_rv_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// ==== test/tb_rv_model.svh ====
// Reference model for the RV32I subset core testbench
// Instruction encoder and in-order architectural execution of one program

`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

typedef enum logic [3:0] {
  K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
  K_ADDI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL
} instr_kind_e;

// One program slot before encoding
typedef struct packed {
  instr_kind_e kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm;
} instr_t;

// Register write as seen on the retirement port
typedef struct packed {
  logic [4:0]  rd;
  logic [31:0] data;
} write_t;

instr_t prog [PROG_WORDS];
write_t exp_q [$];

// ======================================================================
// Encoder, standard RV32I formats
// ======================================================================
function automatic logic [31:0] encode(input instr_t ins);
  logic [31:0] im;
  im = ins.imm;
  case (ins.kind)
    K_SUB:  return {7'b0100000, ins.rs2, ins.rs1, 3'b000, ins.rd, rv_pkg::OP};
    K_AND:  return {7'b0000000, ins.rs2, ins.rs1, 3'b111, ins.rd, rv_pkg::OP};
    K_OR:   return {7'b0000000, ins.rs2, ins.rs1, 3'b110, ins.rd, rv_pkg::OP};
    K_XOR:  return {7'b0000000, ins.rs2, ins.rs1, 3'b100, ins.rd, rv_pkg::OP};
    K_SLT:  return {7'b0000000, ins.rs2, ins.rs1, 3'b010, ins.rd, rv_pkg::OP};
    K_ADDI: return {im[11:0], ins.rs1, 3'b000, ins.rd, rv_pkg::OP_IMM};
    K_LW:   return {im[11:0], ins.rs1, 3'b010, ins.rd, rv_pkg::LOAD};
    K_SW:   return {im[11:5], ins.rs2, ins.rs1, 3'b010, im[4:0], rv_pkg::STORE};
    // B-type scatters the offset, bit 0 dropped
    K_BEQ:  return {im[12], im[10:5], ins.rs2, ins.rs1, 3'b000, im[4:1], im[11], rv_pkg::BRANCH};
    K_BNE:  return {im[12], im[10:5], ins.rs2, ins.rs1, 3'b001, im[4:1], im[11], rv_pkg::BRANCH};
    K_JAL:  return {im[20], im[10:1], im[11], im[19:12], ins.rd, rv_pkg::JAL};
    default: return {7'b0000000, ins.rs2, ins.rs1, 3'b000, ins.rd, rv_pkg::OP};
  endcase
endfunction

// ======================================================================
// Architectural model, one instruction per step
// ======================================================================
task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] dmem [rv_pkg::DMEM_WORDS];
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] res;
  logic        wr;
  int          pc;
  int          next_pc;
  int          steps;
  instr_t      ins;
  foreach (regs[i]) regs[i] = '0;
  foreach (dmem[i]) dmem[i] = '0;
  exp_q.delete();
  // Word index of the current instruction
  pc    = int'(rv_pkg::RESET_VECTOR >> 2);
  steps = 0;
  // Forward-only control flow, so the self-loop is always reached
  while (pc != LOOP_IDX && steps < PROG_WORDS) begin
    ins     = prog[pc];
    a       = regs[ins.rs1];
    b       = regs[ins.rs2];
    addr    = a + ins.imm;
    res     = '0;
    wr      = 1'b1;
    next_pc = pc + 1;
    case (ins.kind)
      K_ADD:  res = a + b;
      K_SUB:  res = a - b;
      K_AND:  res = a & b;
      K_OR:   res = a | b;
      K_XOR:  res = a ^ b;
      K_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      K_ADDI: res = a + ins.imm;
      K_LW:   res = dmem[addr[rv_pkg::DMEM_AW+1:2]];
      K_SW: begin
        dmem[addr[rv_pkg::DMEM_AW+1:2]] = b;
        wr = 1'b0;
      end
      K_BEQ: begin
        wr = 1'b0;
        if (a == b) begin
          next_pc = pc + int'(ins.imm >> 2);
        end
      end
      K_BNE: begin
        wr = 1'b0;
        if (a != b) begin
          next_pc = pc + int'(ins.imm >> 2);
        end
      end
      K_JAL: begin
        res     = 32'((pc + 1) * 4);
        next_pc = pc + int'(ins.imm >> 2);
      end
      default: wr = 1'b0;
    endcase
    // x0 stays zero and never shows on the retirement port
    if (wr && ins.rd != 5'd0) begin
      regs[ins.rd] = res;
      exp_q.push_back('{ins.rd, res});
    end
    pc = next_pc;
    steps++;
  end
endtask

`endif

// ==== test/tb_rv_core.sv ====
// Testbench for the five-stage RV32I subset core
// Random programs from an LCG, loaded through the program port and
// checked in retirement order against a reference model

`timescale 1ns/1ps

module tb_rv_core;

  localparam int CLK_PERIOD  = 10;
  localparam int RST_CYCLES  = 16;
  localparam int NUM_TESTS   = 3;
  localparam int TEST_CYCLES = 200;
  localparam int IDLE_CYCLES = 20;
  // Word index of the closing JAL x0,0
  localparam int LOOP_IDX    = 24;
  localparam int PROG_WORDS  = LOOP_IDX + 1;
  localparam int LOAD_CYCLES = (PROG_WORDS > RST_CYCLES) ? PROG_WORDS : RST_CYCLES;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

  logic                          clk;
  logic                          arst_n;
  logic                          imem_we;
  logic [rv_pkg::IMEM_AW-1:0]    imem_addr;
  logic [rv_pkg::XLEN-1:0]       imem_wdata;
  logic [rv_pkg::XLEN-1:0]       pc_out;
  logic                          retire_valid;
  logic [rv_pkg::REG_ADDR_W-1:0] retire_rd;
  logic [rv_pkg::XLEN-1:0]       retire_data;

  int unsigned lcg_state;
  int          errors;
  int          checks;
  int          ret_idx;
  string       test_names [NUM_TESTS] = '{"alu chains", "load and store", "branch and jump"};

  `include "tb_rv_model.svh"

  rv_core DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .pc_out       (pc_out),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ======================================================================
  // Stimulus helpers
  // ======================================================================
  // LCG, upper bits reduced to the range
  function automatic int rnd(input int range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % 32'(range));
  endfunction

  // Mode 0 ALU only, mode 1 adds loads and stores, mode 2 adds branches and JAL
  task automatic gen_program(input int mode);
    int pick;
    int skip;
    for (int i = 0; i < LOOP_IDX; i++) begin
      pick         = rnd(10);
      prog[i].kind = instr_kind_e'(rnd(6));
      prog[i].rd   = 5'(rnd(8));
      prog[i].rs1  = 5'(rnd(8));
      prog[i].rs2  = 5'(rnd(8));
      prog[i].imm  = 32'(rnd(4096)) - 32'd2048;
      // Reuse recent results, so both forwarding paths get traffic
      if (i > 0 && rnd(2) == 0) begin
        prog[i].rs1 = prog[i-1].rd;
      end
      if (i > 1 && rnd(2) == 0) begin
        prog[i].rs2 = prog[i-2].rd;
      end
      if (pick < 3) begin
        prog[i].kind = K_ADDI;
      end
      if (mode == 1 && i > 0 && prog[i-1].kind == K_LW) begin
        // Load-use pair
        prog[i].kind = K_ADD;
        prog[i].rs1  = prog[i-1].rd;
      end else if (mode == 1 && i > 0 && prog[i-1].kind == K_SW) begin
        // Read back the word just stored
        prog[i].kind = K_LW;
        prog[i].rd   = 5'(1 + rnd(7));
        prog[i].rs1  = '0;
        prog[i].imm  = prog[i-1].imm;
      end else if (mode == 1 && pick >= 5) begin
        prog[i].kind = (pick >= 8) ? K_LW : K_SW;
        prog[i].rd   = 5'(1 + rnd(7));
        prog[i].rs1  = '0;
        prog[i].imm  = 32'(rnd(16) * 4);
      end
      if (mode == 2 && pick >= 6) begin
        // Forward target, never past the self-loop
        skip = 1 + rnd(3);
        if (i + skip > LOOP_IDX) begin
          skip = LOOP_IDX - i;
        end
        prog[i].kind = (pick == 9) ? K_JAL : (pick == 8) ? K_BNE : K_BEQ;
        prog[i].rs1  = 5'(rnd(4));
        prog[i].rs2  = 5'(rnd(4));
        prog[i].imm  = 32'(skip * 4);
      end
    end
    prog[LOOP_IDX].kind = K_JAL;
    prog[LOOP_IDX].rd   = '0;
    prog[LOOP_IDX].rs1  = '0;
    prog[LOOP_IDX].rs2  = '0;
    prog[LOOP_IDX].imm  = '0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // ======================================================================
  // Retirement monitor, sampled on the falling edge
  // ======================================================================
  always @(negedge clk) begin
    if (retire_valid && !arst_n) begin
      errors++;
      $display("A retirement was seen at %0t while reset was asserted", $time);
    end else if (retire_valid && ret_idx < exp_q.size()) begin
      check_value("retire_rd", 32'(retire_rd), 32'(exp_q[ret_idx].rd));
      check_value("retire_data", retire_data, exp_q[ret_idx].data);
      ret_idx++;
    end else if (retire_valid) begin
      errors++;
      $display("Unexpected retirement of x%0d at %0t after the last expected write",
               retire_rd, $time);
      ret_idx++;
    end
  end

  // Reset with program load, run to the last expected write, then idle
  task automatic run_test(input int t);
    int start_errs;
    start_errs = errors;
    gen_program(t);
    run_model();
    ret_idx = 0;
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    for (int c = 0; c < LOAD_CYCLES; c++) begin
      imem_we    = (c < PROG_WORDS);
      imem_addr  = rv_pkg::IMEM_AW'(c);
      imem_wdata = (c < PROG_WORDS) ? encode(prog[c]) : '0;
      @(posedge clk);
      #1;
    end
    imem_we = 1'b0;
    arst_n  = 1'b1;
    @(posedge clk);
    #1;
    check_value("pc_out after reset", pc_out, rv_pkg::RESET_VECTOR);
    while (ret_idx < exp_q.size()) begin
      @(posedge clk);
    end
    // Squashed or looping instructions must stay silent
    repeat (IDLE_CYCLES) @(posedge clk);
    $display("Test %0d %s: %0d of %0d writes retired, %0d failures", t, test_names[t],
             ret_idx, exp_q.size(), errors - start_errs);
  endtask

  // ======================================================================
  // Main sequence and watchdog
  // ======================================================================
  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    lcg_state  = 32'hbbea;
    errors     = 0;
    checks     = 0;
    ret_idx    = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d checks, %0d failures", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the core hung before all tests retired their writes");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== rtl/rv_core.sv ====
// Five-stage RV32I subset core
// Fetch, decode, execute, memory and write-back with forwarding and
// load-use stall, program load port and retirement port

`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          imem_we,
  input  logic [rv_pkg::IMEM_AW-1:0]    imem_addr,
  input  logic [rv_pkg::XLEN-1:0]       imem_wdata,
  output logic [rv_pkg::XLEN-1:0]       pc_out,
  output logic                          retire_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_pkg::XLEN-1:0]       retire_data
);

  // ====================================================================
  // Stage to stage wiring, names match the stage ports
  // ====================================================================
  // IF/ID
  logic [rv_pkg::XLEN-1:0]       ifid_pc;
  logic [rv_pkg::XLEN-1:0]       ifid_instr;
  logic                          ifid_valid;
  // ID/EX
  logic [rv_pkg::XLEN-1:0]       idex_pc;
  logic [rv_pkg::XLEN-1:0]       idex_rs1_data;
  logic [rv_pkg::XLEN-1:0]       idex_rs2_data;
  logic [rv_pkg::REG_ADDR_W-1:0] idex_rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] idex_rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] idex_rd;
  logic [rv_pkg::XLEN-1:0]       idex_imm;
  rv_pkg::alu_op_e               idex_alu_op;
  logic                          idex_alu_src;
  logic                          idex_branch_ne;
  logic                          idex_branch;
  logic                          idex_jump;
  logic                          idex_mem_read;
  logic                          idex_mem_write;
  logic                          idex_reg_write;
  rv_pkg::wb_sel_e               idex_wb_sel;
  // Redirect to fetch
  logic                          redirect;
  logic [rv_pkg::XLEN-1:0]       redirect_pc;
  // EX/MEM
  logic [rv_pkg::XLEN-1:0]       exmem_alu_result;
  logic [rv_pkg::XLEN-1:0]       exmem_store_data;
  logic [rv_pkg::REG_ADDR_W-1:0] exmem_rd;
  logic                          exmem_mem_read;
  logic                          exmem_mem_write;
  logic                          exmem_reg_write;
  rv_pkg::wb_sel_e               exmem_wb_sel;
  logic [rv_pkg::XLEN-1:0]       exmem_pc4;
  // Write-back
  logic                          wb_we;
  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv_pkg::XLEN-1:0]       wb_data;

  rv_hazard_if hz (.clk(clk), .arst_n(arst_n));

  rv_fetch   u_fetch   (.*);
  rv_decode  u_decode  (.*);
  // EX/MEM result feeds back as forwarding source
  rv_execute u_execute (.exmem_result(exmem_alu_result), .*);
  rv_memory  u_memory  (.*);
  rv_hazard  u_hazard  (.*);

  // Retirement, only register writes to rd other than x0
  assign retire_valid = wb_we && wb_rd != '0;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

endmodule

// ==== rtl/rv_hazard.sv ====
// Hazard unit
// Load-use stall, redirect flush and forwarding source selection

`timescale 1ns/1ps

module rv_hazard (
  rv_hazard_if.hazard                  hz,
  input logic [rv_pkg::REG_ADDR_W-1:0] idex_rs1,
  input logic [rv_pkg::REG_ADDR_W-1:0] idex_rs2,
  input logic [rv_pkg::REG_ADDR_W-1:0] idex_rd,
  input logic                          idex_mem_read,
  input logic [rv_pkg::REG_ADDR_W-1:0] exmem_rd,
  input logic                          exmem_reg_write,
  input logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  input logic                          wb_we
);

  logic load_use;

  // Nearest producer wins, x0 never forwarded
  function automatic rv_pkg::fwd_sel_e pick(
    input logic [rv_pkg::REG_ADDR_W-1:0] src
  );
    if (exmem_reg_write && exmem_rd != '0 && exmem_rd == src) begin
      return rv_pkg::FWD_EXMEM;
    end
    if (wb_we && wb_rd != '0 && wb_rd == src) begin
      return rv_pkg::FWD_MEMWB;
    end
    return rv_pkg::FWD_NONE;
  endfunction

  // Load in EX feeding the instruction in ID
  assign load_use = idex_mem_read && idex_rd != '0 &&
                    (idex_rd == hz.id_rs1 || idex_rd == hz.id_rs2);

  assign hz.stall  = load_use;
  assign hz.bubble = load_use;
  assign hz.flush  = hz.redirect;

  always_comb begin
    hz.fwd_a = pick(idex_rs1);
    hz.fwd_b = pick(idex_rs2);
  end

  // Branch in EX excludes a load there
  a_stall_flush: assert property (@(posedge hz.clk) disable iff (!hz.arst_n)
    !(hz.stall && hz.flush));

endmodule

// ==== rtl/rv_memory.sv ====
// Memory and write-back stages
// Word data memory, MEM/WB register and write-back data select

`timescale 1ns/1ps

module rv_memory (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rv_pkg::XLEN-1:0]       exmem_alu_result,
  input  logic [rv_pkg::XLEN-1:0]       exmem_store_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] exmem_rd,
  input  logic                          exmem_mem_read,
  input  logic                          exmem_mem_write,
  input  logic                          exmem_reg_write,
  input  rv_pkg::wb_sel_e               exmem_wb_sel,
  input  logic [rv_pkg::XLEN-1:0]       exmem_pc4,
  output logic                          wb_we,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data
);

  logic [rv_pkg::XLEN-1:0]    dmem [rv_pkg::DMEM_WORDS];
  logic [rv_pkg::DMEM_AW-1:0] addr;
  logic [rv_pkg::XLEN-1:0]    load_data;
  logic [rv_pkg::XLEN-1:0]    memwb_alu;
  logic [rv_pkg::XLEN-1:0]    memwb_load;
  logic [rv_pkg::XLEN-1:0]    memwb_pc4;
  rv_pkg::wb_sel_e            memwb_wb_sel;

  // Word index from byte address
  assign addr = exmem_alu_result[rv_pkg::DMEM_AW+1:2];

  // Data memory, zero after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (exmem_mem_write) begin
      dmem[addr] <= exmem_store_data;
    end
  end

  assign load_data = exmem_mem_read ? dmem[addr] : '0;

  // MEM/WB write strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= exmem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd        <= exmem_rd;
    memwb_alu    <= exmem_alu_result;
    memwb_load   <= load_data;
    memwb_pc4    <= exmem_pc4;
    memwb_wb_sel <= exmem_wb_sel;
  end

  // Write-back source
  always_comb begin
    case (memwb_wb_sel)
      rv_pkg::WB_MEM: wb_data = memwb_load;
      rv_pkg::WB_PC4: wb_data = memwb_pc4;
      default:        wb_data = memwb_alu;
    endcase
  end

endmodule

// ==== rtl/rv_execute.sv ====
// Execute stage
// Forwarding muxes, ALU, branch and jump resolution, EX/MEM register

`timescale 1ns/1ps

module rv_execute (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rv_pkg::XLEN-1:0]       idex_pc,
  input  logic [rv_pkg::XLEN-1:0]       idex_rs1_data,
  input  logic [rv_pkg::XLEN-1:0]       idex_rs2_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] idex_rd,
  input  logic [rv_pkg::XLEN-1:0]       idex_imm,
  input  rv_pkg::alu_op_e               idex_alu_op,
  input  logic                          idex_alu_src,
  input  logic                          idex_branch_ne,
  input  logic                          idex_branch,
  input  logic                          idex_jump,
  input  logic                          idex_mem_read,
  input  logic                          idex_mem_write,
  input  logic                          idex_reg_write,
  input  rv_pkg::wb_sel_e               idex_wb_sel,
  rv_hazard_if.execute                  hz,
  input  logic [rv_pkg::XLEN-1:0]       exmem_result,
  input  logic [rv_pkg::XLEN-1:0]       wb_data,
  output logic                          redirect,
  output logic [rv_pkg::XLEN-1:0]       redirect_pc,
  output logic [rv_pkg::XLEN-1:0]       exmem_alu_result,
  output logic [rv_pkg::XLEN-1:0]       exmem_store_data,
  output logic [rv_pkg::REG_ADDR_W-1:0] exmem_rd,
  output logic                          exmem_mem_read,
  output logic                          exmem_mem_write,
  output logic                          exmem_reg_write,
  output rv_pkg::wb_sel_e               exmem_wb_sel,
  output logic [rv_pkg::XLEN-1:0]       exmem_pc4
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] rs2_fwd;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_y;
  logic [rv_pkg::XLEN-1:0] pc4;
  logic                    taken;

  // Operand source per hazard unit select
  function automatic logic [rv_pkg::XLEN-1:0] fwd_mux(
    input rv_pkg::fwd_sel_e        sel,
    input logic [rv_pkg::XLEN-1:0] reg_val,
    input logic [rv_pkg::XLEN-1:0] ex_val,
    input logic [rv_pkg::XLEN-1:0] wb_val
  );
    case (sel)
      rv_pkg::FWD_EXMEM: return ex_val;
      rv_pkg::FWD_MEMWB: return wb_val;
      default:           return reg_val;
    endcase
  endfunction

  assign op_a    = fwd_mux(hz.fwd_a, idex_rs1_data, exmem_result, wb_data);
  assign rs2_fwd = fwd_mux(hz.fwd_b, idex_rs2_data, exmem_result, wb_data);
  assign op_b    = idex_alu_src ? idex_imm : rs2_fwd;

  // ====================================================================
  // ALU
  // ====================================================================
  always_comb begin
    case (idex_alu_op)
      rv_pkg::ALU_SUB: alu_y = op_a - op_b;
      rv_pkg::ALU_AND: alu_y = op_a & op_b;
      rv_pkg::ALU_OR:  alu_y = op_a | op_b;
      rv_pkg::ALU_XOR: alu_y = op_a ^ op_b;
      rv_pkg::ALU_SLT: alu_y = rv_pkg::XLEN'($signed(op_a) < $signed(op_b));
      default:         alu_y = op_a + op_b;
    endcase
  end

  // ====================================================================
  // Branch and jump resolution
  // ====================================================================
  // Targets are PC relative
  assign taken       = idex_branch && (idex_branch_ne ? (op_a != rs2_fwd) : (op_a == rs2_fwd));
  assign redirect    = taken || idex_jump;
  assign redirect_pc = idex_pc + idex_imm;
  assign hz.redirect = redirect;
  assign pc4         = idex_pc + rv_pkg::XLEN'(4);

  // EX/MEM controls
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exmem_mem_read  <= 1'b0;
      exmem_mem_write <= 1'b0;
      exmem_reg_write <= 1'b0;
    end else begin
      exmem_mem_read  <= idex_mem_read;
      exmem_mem_write <= idex_mem_write;
      exmem_reg_write <= idex_reg_write;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    exmem_alu_result <= alu_y;
    exmem_store_data <= rs2_fwd;
    exmem_rd         <= idex_rd;
    exmem_wb_sel     <= idex_wb_sel;
    exmem_pc4        <= pc4;
  end

  // Instruction behind a redirect enters EX as a no-op
  a_redirect_squash: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> !(idex_branch || idex_jump || idex_mem_read || idex_mem_write ||
                   idex_reg_write));

endmodule

// ==== rtl/rv_decode.sv ====
// Decode stage
// Field split, control generation, register file with write-back bypass
// and the ID/EX register

`timescale 1ns/1ps

module rv_decode (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rv_pkg::XLEN-1:0]       ifid_pc,
  input  logic [rv_pkg::XLEN-1:0]       ifid_instr,
  input  logic                          ifid_valid,
  input  logic                          wb_we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [rv_pkg::XLEN-1:0]       wb_data,
  rv_hazard_if.decode                   hz,
  output logic [rv_pkg::XLEN-1:0]       idex_pc,
  output logic [rv_pkg::XLEN-1:0]       idex_rs1_data,
  output logic [rv_pkg::XLEN-1:0]       idex_rs2_data,
  output logic [rv_pkg::REG_ADDR_W-1:0] idex_rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] idex_rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] idex_rd,
  output logic [rv_pkg::XLEN-1:0]       idex_imm,
  output rv_pkg::alu_op_e               idex_alu_op,
  output logic                          idex_alu_src,
  output logic                          idex_branch_ne,
  output logic                          idex_branch,
  output logic                          idex_jump,
  output logic                          idex_mem_read,
  output logic                          idex_mem_write,
  output logic                          idex_reg_write,
  output rv_pkg::wb_sel_e               idex_wb_sel
);

  rv_pkg::rv_opcode_e            opcode;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [2:0]                    funct3;
  logic [rv_pkg::XLEN-1:0]       imm_i;
  logic [rv_pkg::XLEN-1:0]       imm_s;
  logic [rv_pkg::XLEN-1:0]       imm_b;
  logic [rv_pkg::XLEN-1:0]       imm_j;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic [rv_pkg::XLEN-1:0]       regs [2**rv_pkg::REG_ADDR_W];
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  rv_pkg::alu_op_e               alu_f3;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::wb_sel_e               wb_sel;
  logic                          alu_src;
  logic                          branch;
  logic                          jump;
  logic                          mem_read;
  logic                          mem_write;
  logic                          reg_write;
  logic                          kill;

  // ====================================================================
  // Fields and immediates
  // ====================================================================
  assign opcode = rv_pkg::rv_opcode_e'(ifid_instr[6:0]);
  assign rd     = ifid_instr[11:7];
  assign funct3 = ifid_instr[14:12];
  assign rs1    = ifid_instr[19:15];
  assign rs2    = ifid_instr[24:20];
  assign imm_i  = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
  assign imm_s  = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
  assign imm_b  = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
                   ifid_instr[30:25], ifid_instr[11:8], 1'b0};
  assign imm_j  = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
                   ifid_instr[20], ifid_instr[30:21], 1'b0};

  // Sources for load-use check
  assign hz.id_rs1 = rs1;
  assign hz.id_rs2 = rs2;

  // ALU op from funct3, bit 30 picks SUB for register ops only
  always_comb begin
    case (funct3)
      3'b111:  alu_f3 = rv_pkg::ALU_AND;
      3'b110:  alu_f3 = rv_pkg::ALU_OR;
      3'b100:  alu_f3 = rv_pkg::ALU_XOR;
      3'b010:  alu_f3 = rv_pkg::ALU_SLT;
      default: alu_f3 = (opcode == rv_pkg::OP && ifid_instr[30]) ?
                        rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
    endcase
  end

  // ====================================================================
  // Control, invalid or unknown opcode gives a no-op
  // ====================================================================
  always_comb begin
    alu_op    = rv_pkg::ALU_ADD;
    wb_sel    = rv_pkg::WB_ALU;
    imm       = imm_i;
    alu_src   = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    if (ifid_valid) begin
      case (opcode)
        rv_pkg::OP: begin
          alu_op    = alu_f3;
          reg_write = 1'b1;
        end
        rv_pkg::OP_IMM: begin
          alu_op    = alu_f3;
          alu_src   = 1'b1;
          reg_write = 1'b1;
        end
        rv_pkg::LOAD: begin
          alu_src   = 1'b1;
          mem_read  = 1'b1;
          reg_write = 1'b1;
          wb_sel    = rv_pkg::WB_MEM;
        end
        rv_pkg::STORE: begin
          alu_src   = 1'b1;
          mem_write = 1'b1;
          imm       = imm_s;
        end
        rv_pkg::BRANCH: begin
          branch = 1'b1;
          imm    = imm_b;
        end
        rv_pkg::JAL: begin
          jump      = 1'b1;
          reg_write = 1'b1;
          wb_sel    = rv_pkg::WB_PC4;
          imm       = imm_j;
        end
        default: ;
      endcase
    end
  end

  // ====================================================================
  // Register file, zero after reset, x0 never written
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle write-back wins over stored value
  assign rs1_data = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

  // ====================================================================
  // ID/EX register
  // ====================================================================
  // No-op on load-use bubble or redirect squash
  assign kill = hz.bubble || hz.flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idex_branch_ne <= 1'b0;
      idex_branch    <= 1'b0;
      idex_jump      <= 1'b0;
      idex_mem_read  <= 1'b0;
      idex_mem_write <= 1'b0;
      idex_reg_write <= 1'b0;
    end else begin
      idex_branch_ne <= funct3[0] && !kill;
      idex_branch    <= branch && !kill;
      idex_jump      <= jump && !kill;
      idex_mem_read  <= mem_read && !kill;
      idex_mem_write <= mem_write && !kill;
      idex_reg_write <= reg_write && !kill;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    idex_pc       <= ifid_pc;
    idex_rs1_data <= rs1_data;
    idex_rs2_data <= rs2_data;
    idex_rs1      <= rs1;
    idex_rs2      <= rs2;
    idex_rd       <= rd;
    idex_imm      <= imm;
    idex_alu_op   <= alu_op;
    idex_alu_src  <= alu_src;
    idex_wb_sel   <= wb_sel;
  end

endmodule

// ==== rtl/rv_fetch.sv ====
// Fetch stage
// PC register, instruction memory with load port and IF/ID register

`timescale 1ns/1ps

module rv_fetch (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       imem_we,
  input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
  input  logic [rv_pkg::XLEN-1:0]    imem_wdata,
  input  logic                       redirect,
  input  logic [rv_pkg::XLEN-1:0]    redirect_pc,
  rv_hazard_if.decode                hz,
  output logic [rv_pkg::XLEN-1:0]    ifid_pc,
  output logic [rv_pkg::XLEN-1:0]    ifid_instr,
  output logic                       ifid_valid,
  output logic [rv_pkg::XLEN-1:0]    pc_out
);

  logic [rv_pkg::XLEN-1:0] imem [rv_pkg::IMEM_WORDS];
  logic [rv_pkg::XLEN-1:0] pc;
  logic [rv_pkg::XLEN-1:0] instr;
  // Set on first edge out of reset
  logic                    run;

  // Program load, one word per cycle
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // Asynchronous word read at PC
  assign instr  = imem[pc[rv_pkg::IMEM_AW+1:2]];
  assign pc_out = pc;

  // PC holds at reset vector for the first edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
      pc  <= rv_pkg::RESET_VECTOR;
    end else begin
      run <= 1'b1;
      if (redirect) begin
        pc <= redirect_pc;
      end else if (run && !hz.stall) begin
        pc <= pc + rv_pkg::XLEN'(4);
      end
    end
  end

  // IF/ID valid, squashed on redirect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ifid_valid <= 1'b0;
    end else if (hz.flush) begin
      ifid_valid <= 1'b0;
    end else if (!hz.stall) begin
      ifid_valid <= run;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!hz.stall) begin
      ifid_pc    <= pc;
      ifid_instr <= instr;
    end
  end

  // Program load only while core held in reset
  a_load_in_reset: assert property (@(posedge clk) arst_n |-> !imem_we);

endmodule

// ==== rtl/rv_hazard_if.sv ====
// Pipeline hazard control bundle
// Stall, bubble, flush and forwarding selects between hazard unit and stages

`timescale 1ns/1ps

interface rv_hazard_if (
  input logic clk,
  input logic arst_n
);

  // Driven by hazard unit
  logic                          stall;
  logic                          bubble;
  logic                          flush;
  rv_pkg::fwd_sel_e              fwd_a;
  rv_pkg::fwd_sel_e              fwd_b;
  // Driven by execute
  logic                          redirect;
  // Source registers of the instruction in ID
  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2;

  modport hazard (
    input  clk, arst_n, redirect, id_rs1, id_rs2,
    output stall, bubble, flush, fwd_a, fwd_b
  );
  modport decode (input stall, bubble, flush, output id_rs1, id_rs2);
  modport execute (input fwd_a, fwd_b, output redirect);

endinterface

// ==== rtl/rv_pkg.sv ====
// RV32I subset core definitions
// Opcode, ALU, write-back and forwarding encodings
// Widths, memory depths and reset vector

package rv_pkg;

  // ====================================================================
  // Widths and sizes
  // ====================================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Instruction memory, word addressed
  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW    = 8;

  // Data memory, word addressed
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;

  // First fetch address
  localparam logic [XLEN-1:0] RESET_VECTOR = '0;

  // ====================================================================
  // Encodings
  // ====================================================================
  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } rv_opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_NONE  = 2'd0,
    FWD_EXMEM = 2'd1,
    FWD_MEMWB = 2'd2
  } fwd_sel_e;

endpackage
